// ==== Makefile ====
# verilator build and run of the uart port testbench
# the simulator exits with a failing status when a check fails

SRCS := $(filter-out +%,$(shell cat project.f))

.PHONY: all run clean

all: obj_dir/Vuart_port_tb

# rebuilt only when the file list or one of the sources changes
obj_dir/Vuart_port_tb: project.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ps -j 0 \
		--top-module uart_port_tb -f project.f

run: obj_dir/Vuart_port_tb
	./obj_dir/Vuart_port_tb

clean:
	rm -rf obj_dir

// ==== project.f ====
source/uart_pkg.sv
source/uart_rx_filter.sv
source/uart_rx.sv
source/uart_tx.sv
source/uart_port.sv
tb/uart_port_tb.sv

// ==== source/uart_pkg.sv ====
/*
 * uart definitions shared by the receiver, the transmitter and the top level
 * covers the data byte, the receive result and both state encodings
 */

package uart_pkg;

  // one data byte as carried by a frame of 8 data bits
  typedef logic [7:0] uart_byte_t;

  // outcome of one received frame as presented to the host
  // frame_err is set when the stop bit was sampled low
  typedef struct packed {
    uart_byte_t data;
    logic       frame_err;
  } uart_rx_t;

  // receiver states in frame order
  // rx_wait_go_low holds the result until the host drops go
  typedef enum logic [2:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop,
    rx_wait_go_low
  } rx_state_e;

  // transmitter states, the same exchange seen from the sending side
  typedef enum logic [2:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_stop,
    tx_wait_go_low
  } tx_state_e;

endpackage

// ==== source/uart_port.sv ====
/*
 * uart port with filtered receive path and transmit path side by side
 * both directions use the go level exchange with the host
 */
`timescale 1ns/1ps

module uart_port #(
  parameter int clk_freq  = 1_600_000,
  parameter int baud_rate = 100_000
) (
  input  logic                clk,
  input  logic                rst_n,
  // receive side
  input  logic                rx,
  input  logic                rx_go,
  output uart_pkg::uart_rx_t   rx_result,
  output logic                rx_ready,
  // transmit side
  input  logic                tx_go,
  input  uart_pkg::uart_byte_t tx_data,
  output logic                txd,
  output logic                tx_done
);

  // rx after synchronization and glitch removal
  logic rx_clean;

  // the raw line is asynchronous, so it is cleaned before any sampling
  uart_rx_filter rx_filter_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_clean (rx_clean)
  );

  // the receiver sees the line four cycles late, which only shifts its
  // sample points and not their spacing
  uart_rx #(
    .clk_freq  (clk_freq),
    .baud_rate (baud_rate)
  ) rx_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx_clean (rx_clean),
    .go       (rx_go),
    .result   (rx_result),
    .ready    (rx_ready)
  );

  uart_tx #(
    .clk_freq  (clk_freq),
    .baud_rate (baud_rate)
  ) tx_i (
    .clk   (clk),
    .rst_n (rst_n),
    .go    (tx_go),
    .data  (tx_data),
    .txd   (txd),
    .done  (tx_done)
  );

endmodule

// ==== source/uart_rx.sv ====
/*
 * uart receiver for 8 data bits, no parity and one stop bit
 * host asks with go, gets ready with the result and releases with go low
 */
`timescale 1ns/1ps

module uart_rx #(
  parameter int clk_freq  = 1_600_000,
  parameter int baud_rate = 100_000
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              rx_clean,
  input  logic              go,
  output uart_pkg::uart_rx_t result,
  output logic              ready
);

  import uart_pkg::*;

  // clock cycles per bit
  localparam int bit_time = clk_freq / baud_rate;
  localparam int cnt_w = (bit_time == 1) ? 1 : $clog2(bit_time);

  // the first wait lands on the middle of the start bit
  // one cycle of it has already gone by when idle sees the low line
  localparam logic [cnt_w-1:0] half_load =
    (bit_time == 1) ? '0 : cnt_w'(bit_time / 2 - 1);
  // later waits are a whole bit, again less the cycle spent switching
  localparam logic [cnt_w-1:0] full_load = cnt_w'(bit_time - 1);

  rx_state_e        state_q;
  logic [cnt_w-1:0] cnt_q;
  logic [2:0]       bit_idx_q;
  // bits arrive LSB first and are shifted in from the top
  uart_byte_t       shift_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= rx_idle;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      result    <= '0;
      ready     <= 1'b0;
    end else begin
      unique case (state_q)

        rx_idle: begin
          // only a start edge seen while the host is waiting opens a frame
          if (go && !rx_clean) begin
            cnt_q     <= half_load;
            bit_idx_q <= '0;
            // with one cycle per bit the start bit is already behind us
            state_q   <= (bit_time == 1) ? rx_data : rx_start;
          end
        end

        rx_start: begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == '0) begin
            // now in the middle of the start bit, so the next sample is
            // a whole bit away in the middle of data bit 0
            cnt_q     <= full_load;
            bit_idx_q <= '0;
            state_q   <= rx_data;
          end
        end

        rx_data: begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == '0) begin
            shift_q   <= {rx_clean, shift_q[7:1]};
            cnt_q     <= full_load;
            bit_idx_q <= bit_idx_q + 1'b1;
            // the index still shows the bit being taken on this edge
            if (bit_idx_q == 3'd7) begin
              state_q <= rx_stop;
            end
          end
        end

        rx_stop: begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == '0) begin
            // a low stop bit still hands over the byte, flagged as bad
            result.data      <= shift_q;
            result.frame_err <= !rx_clean;
            ready            <= 1'b1;
            state_q          <= rx_wait_go_low;
          end
        end

        rx_wait_go_low: begin
          // result and ready stay put until the host lets go
          if (!go) begin
            result  <= '0;
            ready   <= 1'b0;
            state_q <= rx_idle;
          end
        end

        default: begin
          state_q <= rx_idle;
        end

      endcase
    end
  end

  // no re-alignment on the start bit, so the sample points rely on the
  // sender's clock being close to ours for the length of one frame

endmodule

// ==== source/uart_rx_filter.sv ====
/*
 * rx input conditioning with a two stage synchronizer and a glitch filter
 * the output only moves once three synchronized samples agree
 */
`timescale 1ns/1ps

module uart_rx_filter (
  input  logic clk,
  input  logic rst_n,
  input  logic rx,
  output logic rx_clean
);

  // sync_q[0] may go metastable, sync_q[1] is the first usable sample
  logic [1:0] sync_q;
  // the two samples taken before the current synchronized one
  logic [1:0] hist_q;
  // last accepted level, kept while the samples disagree
  logic       level_q;
  logic [2:0] window;
  logic       agree;

  // the newest sample sits in bit 0 of the window
  assign window = {hist_q, sync_q[1]};
  assign agree  = (window == 3'b000) || (window == 3'b111);

  // a level that three samples in a row confirm passes straight through
  // anything shorter keeps the previous accepted level
  assign rx_clean = agree ? window[0] : level_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // the line idles high, so everything starts at 1
      sync_q  <= 2'b11;
      hist_q  <= 2'b11;
      level_q <= 1'b1;
    end else begin
      sync_q  <= {sync_q[0], rx};
      hist_q  <= {hist_q[0], sync_q[1]};
      level_q <= rx_clean;
    end
  end

  // a change of rx needs two edges to cross the synchronizer and two more
  // to fill the window, so rx_clean follows four cycles after rx
  // pulses of one or two cycles never fill the window and are dropped

endmodule

// ==== source/uart_tx.sv ====
/*
 * uart transmitter for 8 data bits, no parity and one stop bit
 * the byte is latched on go and done is held until go falls
 */
`timescale 1ns/1ps

module uart_tx #(
  parameter int clk_freq  = 1_600_000,
  parameter int baud_rate = 100_000
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                go,
  input  uart_pkg::uart_byte_t data,
  output logic                txd,
  output logic                done
);

  import uart_pkg::*;

  // clock cycles per bit
  localparam int bit_time = clk_freq / baud_rate;
  localparam int cnt_w = (bit_time == 1) ? 1 : $clog2(bit_time);
  // the edge that changes txd counts as the first cycle of the bit
  localparam logic [cnt_w-1:0] full_load = cnt_w'(bit_time - 1);

  tx_state_e        state_q;
  logic [cnt_w-1:0] cnt_q;
  logic [2:0]       bit_idx_q;
  // latched byte, shifted right so bit 0 is always the next to send
  uart_byte_t       shift_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= tx_idle;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      txd       <= 1'b1;
      done      <= 1'b0;
    end else begin
      unique case (state_q)

        tx_idle: begin
          // the byte is taken on this edge and the start bit begins with it
          if (go) begin
            shift_q <= data;
            txd     <= 1'b0;
            cnt_q   <= full_load;
            state_q <= tx_start;
          end
        end

        tx_start: begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == '0) begin
            txd       <= shift_q[0];
            shift_q   <= shift_q >> 1;
            bit_idx_q <= '0;
            cnt_q     <= full_load;
            state_q   <= tx_data;
          end
        end

        tx_data: begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == '0) begin
            cnt_q <= full_load;
            // after bit 7 has had its full time the stop bit follows
            if (bit_idx_q == 3'd7) begin
              txd     <= 1'b1;
              state_q <= tx_stop;
            end else begin
              txd       <= shift_q[0];
              shift_q   <= shift_q >> 1;
              bit_idx_q <= bit_idx_q + 1'b1;
            end
          end
        end

        tx_stop: begin
          cnt_q <= cnt_q - 1'b1;
          // done comes once the stop bit has been on the line a full bit
          if (cnt_q == '0) begin
            done    <= 1'b1;
            state_q <= tx_wait_go_low;
          end
        end

        tx_wait_go_low: begin
          // the line stays idle high while the host keeps go raised
          if (!go) begin
            done    <= 1'b0;
            state_q <= tx_idle;
          end
        end

        default: begin
          state_q <= tx_idle;
        end

      endcase
    end
  end

endmodule

// ==== tb/uart_port_tb.sv ====
/*
 * testbench for the uart port, covering receive, framing errors, gating,
 * transmit and a txd to rx loopback at 16 cycles per bit
 */
`timescale 1ns/1ps

module uart_port_tb;

  import uart_pkg::*;

  localparam int clk_freq   = 1_600_000;
  localparam int baud_rate  = 100_000;
  localparam int bit_cycles = clk_freq / baud_rate;

  logic       clk;
  logic       rst_n;
  logic       rx_drv;
  logic       loop_en;
  logic       rx_line;
  logic       rx_go;
  logic       tx_go;
  uart_byte_t tx_data;
  uart_rx_t   rx_result;
  logic       rx_ready;
  logic       txd;
  logic       tx_done;

  // state of the random source, stepped once per bit taken
  logic [15:0] lfsr_q;
  // results the receiver still owes, in frame order
  uart_rx_t    exp_q[$];
  uart_rx_t    held_result;
  logic        ready_seen;

  // in loopback the transmitter feeds the receiver
  assign rx_line = loop_en ? txd : rx_drv;

  uart_port #(
    .clk_freq  (clk_freq),
    .baud_rate (baud_rate)
  ) dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx_line),
    .rx_go     (rx_go),
    .rx_result (rx_result),
    .rx_ready  (rx_ready),
    .tx_go     (tx_go),
    .tx_data   (tx_data),
    .txd       (txd),
    .tx_done   (tx_done)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // galois form with taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic [15:0] nxt;
    nxt = state >> 1;
    if (state[0]) begin
      nxt = nxt ^ 16'hB400;
    end
    return nxt;
  endfunction

  task automatic next_random_byte(output uart_byte_t value);
    for (int i = 0; i < 8; i++) begin
      lfsr_q   = lfsr_next(lfsr_q);
      value[i] = lfsr_q[0];
    end
  endtask

  // serial frame in line order, bit 0 is the start bit and bit 9 the stop bit
  function automatic logic [9:0] build_frame(input uart_byte_t value, input logic stop_bit);
    return {stop_bit, value, 1'b0};
  endfunction

  // what the host should read back for a frame with this byte and stop bit
  function automatic uart_rx_t expect_result(input uart_byte_t value, input logic stop_bit);
    uart_rx_t res;
    res.data      = value;
    res.frame_err = !stop_bit;
    return res;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  task automatic check_result(input string name, input uart_rx_t got, input uart_rx_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t: %s is data=%h frame_err=%b, expected data=%h frame_err=%b",
                          $time, name, got.data, got.frame_err, exp.data, exp.frame_err));
    end
  endtask

  task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  // each wait samples on falling edges and gives up after its own limit
  task automatic wait_rx_ready(input logic level, input int limit);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > limit) begin
        abort_run($sformatf("timeout: rx_ready did not go to %b within %0d cycles", level, limit));
      end
    end while (rx_ready !== level);
  endtask

  task automatic wait_tx_done(input logic level, input int limit);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > limit) begin
        abort_run($sformatf("timeout: tx_done did not go to %b within %0d cycles", level, limit));
      end
    end while (tx_done !== level);
  endtask

  task automatic wait_txd_low(input int limit);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > limit) begin
        abort_run($sformatf("timeout: txd start bit did not begin within %0d cycles", limit));
      end
    end while (txd !== 1'b0);
  endtask

  // plays one frame onto rx from the next rising edge, then idles the line high
  task automatic drive_frame(input logic [9:0] frame);
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      rx_drv <= frame[i];
      repeat (bit_cycles - 1) @(posedge clk);
    end
    @(posedge clk);
    rx_drv <= 1'b1;
  endtask

  task automatic receive_frame(input uart_byte_t value, input logic stop_bit);
    // one idle bit lets the filter settle after a low stop bit
    repeat (bit_cycles) @(posedge clk);
    rx_go <= 1'b1;
    exp_q.push_back(expect_result(value, stop_bit));
    drive_frame(build_frame(value, stop_bit));
    wait_rx_ready(1'b1, 4 * bit_cycles);
    @(posedge clk);
    rx_go <= 1'b0;
    wait_rx_ready(1'b0, 4);
    check_result("rx_result after release", rx_result, '0);
  endtask

  task automatic transmit_byte(input uart_byte_t value);
    logic [9:0] exp_frame;
    uart_byte_t got;
    exp_frame = build_frame(value, 1'b1);
    @(posedge clk);
    tx_go   <= 1'b1;
    tx_data <= value;
    // the byte is latched on this edge, so the input may move on
    @(posedge clk);
    tx_data <= ~value;
    wait_txd_low(4);
    // from half a cycle after the falling edge to the middle of the start bit
    repeat (bit_cycles / 2 - 1) @(negedge clk);
    check_bit("txd start bit", txd, exp_frame[0]);
    for (int i = 0; i < 8; i++) begin
      repeat (bit_cycles) @(negedge clk);
      got[i] = txd;
    end
    check_byte("txd data", got, value);
    repeat (bit_cycles) @(negedge clk);
    check_bit("txd stop bit", txd, exp_frame[9]);
    // done comes exactly ten bit times after the start edge
    repeat (bit_cycles / 2) @(negedge clk);
    check_bit("tx_done before end of stop bit", tx_done, 1'b0);
    @(negedge clk);
    check_bit("tx_done at end of frame", tx_done, 1'b1);
    repeat (bit_cycles) begin
      @(negedge clk);
      check_bit("tx_done while tx_go held", tx_done, 1'b1);
      check_bit("txd while tx_go held", txd, 1'b1);
    end
    @(posedge clk);
    tx_go <= 1'b0;
    wait_tx_done(1'b0, 4);
  endtask

  task automatic loopback_byte(input uart_byte_t value);
    @(posedge clk);
    rx_go   <= 1'b1;
    tx_go   <= 1'b1;
    tx_data <= value;
    exp_q.push_back(expect_result(value, 1'b1));
    wait_rx_ready(1'b1, 12 * bit_cycles);
    wait_tx_done(1'b1, 2 * bit_cycles);
    @(posedge clk);
    rx_go <= 1'b0;
    tx_go <= 1'b0;
    wait_rx_ready(1'b0, 4);
    wait_tx_done(1'b0, 4);
    repeat (bit_cycles) @(posedge clk);
  endtask

  // compares each result when rx_ready rises and watches it stay stable
  always @(negedge clk) begin
    if (rx_ready && !ready_seen) begin
      if (exp_q.size() == 0) begin
        abort_run("rx_ready rose although no frame was expected");
      end else begin
        held_result = exp_q.pop_front();
        check_result("rx_result", rx_result, held_result);
      end
    end else if (rx_ready) begin
      check_result("rx_result while rx_ready held", rx_result, held_result);
    end
    ready_seen = rx_ready;
  end

  initial begin
    uart_byte_t value;
    rst_n      = 1'b0;
    rx_drv     = 1'b1;
    loop_en    = 1'b0;
    rx_go      = 1'b0;
    tx_go      = 1'b0;
    tx_data    = '0;
    lfsr_q     = 16'd37;
    ready_seen = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    // idle outputs after reset and before any go
    repeat (20) begin
      @(negedge clk);
      check_bit("rx_ready after reset", rx_ready, 1'b0);
      check_bit("tx_done after reset", tx_done, 1'b0);
      check_bit("txd after reset", txd, 1'b1);
      check_result("rx_result after reset", rx_result, '0);
    end

    repeat (20) begin
      next_random_byte(value);
      receive_frame(value, 1'b1);
    end

    // low stop bits, then a good frame to show the receiver recovered
    repeat (4) begin
      next_random_byte(value);
      receive_frame(value, 1'b0);
    end
    next_random_byte(value);
    receive_frame(value, 1'b1);

    // a frame with rx_go low must be ignored for two frame times
    next_random_byte(value);
    drive_frame(build_frame(value, 1'b1));
    repeat (10 * bit_cycles) begin
      @(negedge clk);
      check_bit("rx_ready while rx_go low", rx_ready, 1'b0);
    end
    next_random_byte(value);
    receive_frame(value, 1'b1);

    repeat (20) begin
      next_random_byte(value);
      transmit_byte(value);
    end

    @(posedge clk);
    loop_en <= 1'b1;
    repeat (10) begin
      next_random_byte(value);
      loopback_byte(value);
    end

    if (exp_q.size() != 0) begin
      abort_run($sformatf("%0d expected frames were never received", exp_q.size()));
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule
